//--- bench/mips_mem_wb_checker.sv
`timescale 1ns/1ps

module mips_mem_wb_checker
(
    input  logic                                i_clk,
    input  logic                                i_rst_n,
    input  mips_mem_wb_pkg::mem_stage_t         i_mem,
    input  logic                                i_exp_push,
    input  mips_mem_wb_pkg::wb_write_t          i_exp,
    input  mips_mem_wb_pkg::wb_write_t          i_wb,
    input  logic [mips_mem_wb_pkg::RNBITS-1:0]  i_raddr_a,
    input  logic [mips_mem_wb_pkg::RNBITS-1:0]  i_raddr_b,
    input  logic [mips_mem_wb_pkg::NBITS-1:0]   i_rdata_a,
    input  logic [mips_mem_wb_pkg::NBITS-1:0]   i_rdata_b,
    output int                                  o_mismatches,
    output int                                  o_errors,
    output int                                  o_pending
);

    localparam int NBITS  = mips_mem_wb_pkg::NBITS;
    localparam int RNBITS = mips_mem_wb_pkg::RNBITS;

    mips_mem_wb_pkg::wb_write_t expect_q [$];
    logic [NBITS-1:0]           shadow [mips_mem_wb_pkg::NREGS];    // Expected register contents.
    logic                       in_wb;                              // Valid bundle now in WB.

    // Register zero, then the write in flight, then the stored copy.
    function automatic logic [NBITS-1:0] model_read(input logic [RNBITS-1:0] addr,
                                                    input mips_mem_wb_pkg::wb_write_t w);
        logic [NBITS-1:0] value;
        if (addr == '0)
            value = '0;
        else if (w.en && (w.rd == addr))
            value = w.data;
        else
            value = shadow[addr];
        return value;
    endfunction

    task automatic compare_value(input string name, input logic [NBITS-1:0] expected,
                                 input logic [NBITS-1:0] actual);
        if (actual !== expected)
        begin
            o_mismatches++;
            $display("mismatch at %0t: %s expected %h, actual %h", $time, name, expected, actual);
        end
    endtask

    initial
    begin
        o_mismatches = 0;
        o_errors     = 0;
        o_pending    = 0;
    end

    always @(posedge i_clk)
    begin
        mips_mem_wb_pkg::wb_write_t cur;
        cur = '0;
        if (!i_rst_n)
        begin
            in_wb = 1'b0;
            expect_q.delete();
            for (int r = 0; r < mips_mem_wb_pkg::NREGS; r++)
            begin
                shadow[r] = '0;
            end
        end
        else
        begin
            if (in_wb && (expect_q.size() == 0))
            begin
                o_errors++;
                $display("error at %0t: valid writeback but no expected result was queued", $time);
            end
            else if (in_wb)
            begin
                cur = expect_q.pop_front();
                compare_value("o_wb.en", NBITS'(cur.en), NBITS'(i_wb.en));
                compare_value("o_wb.rd", NBITS'(cur.rd), NBITS'(i_wb.rd));
                if (cur.en)
                    compare_value("o_wb.data", cur.data, i_wb.data);
            end
            else
            begin
                compare_value("o_wb.en", '0, NBITS'(i_wb.en));  // Bubble in WB.
            end
            compare_value("o_rdata_a", model_read(i_raddr_a, cur), i_rdata_a);
            compare_value("o_rdata_b", model_read(i_raddr_b, cur), i_rdata_b);
            if (cur.en)
                shadow[cur.rd] = cur.data;
            if (i_exp_push)
                expect_q.push_back(i_exp);
            in_wb = i_mem.valid;
        end
        o_pending = expect_q.size();
    end

endmodule

//--- bench/mips_mem_wb_tb.sv
`timescale 1ns/1ps

module mips_mem_wb_tb;

    localparam int NBITS  = mips_mem_wb_pkg::NBITS;
    localparam int RNBITS = mips_mem_wb_pkg::RNBITS;

    logic                           clk;
    logic                           rst_n;
    mips_mem_wb_pkg::mem_stage_t    mem;
    logic [RNBITS-1:0]              raddr_a;
    logic [RNBITS-1:0]              raddr_b;
    mips_mem_wb_pkg::wb_write_t     wb;
    logic [NBITS-1:0]               rdata_a;
    logic [NBITS-1:0]               rdata_b;
    logic                           exp_push;
    mips_mem_wb_pkg::wb_write_t     exp_wb;
    int                             mismatches;
    int                             errors;
    int                             pending;
    int                             tb_errors;
    int                             cycle_limit;
    int                             cycles;

    mips_mem_wb_pkg::mem_stage_t    stim_q [$];
    mips_mem_wb_pkg::wb_write_t     expect_q [$];
    bit                             b2b_q [$];      // No bubble before this line.

    mips_mem_wb_top i_dut
    (
        .i_clk      (clk),
        .i_rst_n    (rst_n),
        .i_mem      (mem),
        .i_raddr_a  (raddr_a),
        .i_raddr_b  (raddr_b),
        .o_wb       (wb),
        .o_rdata_a  (rdata_a),
        .o_rdata_b  (rdata_b)
    );

    mips_mem_wb_checker u_checker
    (
        .i_clk          (clk),
        .i_rst_n        (rst_n),
        .i_mem          (mem),
        .i_exp_push     (exp_push),
        .i_exp          (exp_wb),
        .i_wb           (wb),
        .i_raddr_a      (raddr_a),
        .i_raddr_b      (raddr_b),
        .i_rdata_a      (rdata_a),
        .i_rdata_b      (rdata_b),
        .o_mismatches   (mismatches),
        .o_errors       (errors),
        .o_pending      (pending)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic read_tests();
        int fd;
        int n;
        string line;
        logic [31:0] f [16];
        mips_mem_wb_pkg::mem_stage_t s;
        mips_mem_wb_pkg::wb_write_t e;
        fd = $fopen("bench/mips_mem_wb_tests.txt", "r");
        if (fd == 0)
        begin
            tb_errors++;
            $display("error: cannot open bench/mips_mem_wb_tests.txt");
            return;
        end
        while (!$feof(fd))
        begin
            n = $fgets(line, fd);
            if ((n > 1) && (line.getc(0) != "#"))
            begin
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                            f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
                            f[8], f[9], f[10], f[11], f[12], f[13], f[14], f[15]);
                if (n != 16)
                begin
                    tb_errors++;
                    $display("error: test line has %0d fields instead of 16", n);
                end
                else
                begin
                    s.valid          = f[1][0];
                    s.mem_op         = mips_mem_wb_pkg::mem_op_e'(f[2][1:0]);
                    s.store_size     = mips_mem_wb_pkg::access_size_e'(f[3][1:0]);
                    s.alu_result     = f[4];
                    s.store_data     = f[5];
                    s.extension      = f[6];
                    s.rd             = f[7][RNBITS-1:0];
                    s.wb.reg_write   = f[8][0];
                    s.wb.mem_to_reg  = f[9][0];
                    s.wb.load_size   = mips_mem_wb_pkg::access_size_e'(f[10][1:0]);
                    s.wb.zero_extend = f[11][0];
                    s.wb.lui         = f[12][0];
                    e.en             = f[13][0];
                    e.rd             = f[14][RNBITS-1:0];
                    e.data           = f[15];
                    b2b_q.push_back(f[0][0]);
                    stim_q.push_back(s);
                    expect_q.push_back(e);
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic drive_bubble(input logic [RNBITS-1:0] last_rd);
        @(negedge clk);
        mem      = '0;
        exp_push = 1'b0;
        raddr_a  = last_rd;
        raddr_b  = RNBITS'($urandom_range(31, 0));
    endtask

    // Run limit from the number of test lines.
    initial
    begin
        cycles = 0;
        wait (cycle_limit > 0);
        while (cycles < cycle_limit)
        begin
            @(posedge clk);
            cycles++;
        end
        $display("error: run did not finish within %0d cycles", cycle_limit);
        $display("mismatches: %0d, other errors: %0d", mismatches, errors + tb_errors + 1);
        $display("TEST FAILED");
        $finish;
    end

    initial
    begin
        int gap;
        logic [RNBITS-1:0] last_rd;
        rst_n     = 1'b0;
        mem       = '0;
        raddr_a   = '0;
        raddr_b   = '0;
        exp_push  = 1'b0;
        exp_wb    = '0;
        last_rd   = '0;
        tb_errors = 0;
        void'($urandom(90));
        read_tests();
        if (stim_q.size() == 0)
        begin
            tb_errors++;
            $display("error: no test lines were read");
        end
        cycle_limit = 4 * stim_q.size() + 50;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < stim_q.size(); i++)
        begin
            gap = b2b_q[i] ? 0 : int'($urandom_range(2, 0));
            repeat (gap) drive_bubble(last_rd);
            @(negedge clk);
            mem      = stim_q[i];
            exp_wb   = expect_q[i];
            exp_push = stim_q[i].valid;
            raddr_b  = raddr_a;
            raddr_a  = last_rd;
            last_rd  = stim_q[i].rd;
        end
        drive_bubble(last_rd);
        while (pending != 0)
            @(negedge clk);
        drive_bubble(last_rd);      // Last write read from storage.
        @(negedge clk);
        $display("mismatches: %0d, other errors: %0d", mismatches, errors + tb_errors);
        if ((mismatches == 0) && (errors == 0) && (tb_errors == 0))
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

//--- bench/mips_mem_wb_tests.txt
# b2b valid mem_op store_size alu_result store_data extension rd reg_write mem_to_reg
# load_size zero_extend lui exp_en exp_rd exp_data (hex, b2b=1 means no bubble before)
0 1 0 0 12345678 00000000 00000000 01 1 0 0 0 0 1 01 12345678
0 1 0 0 cafef00d 00000000 00000000 02 1 0 0 0 0 1 02 cafef00d
0 1 0 0 deadbeef 00000000 00000000 03 0 0 0 0 0 0 03 00000000
0 0 0 0 11111111 00000000 00000000 04 1 0 0 0 0 0 04 00000000
0 1 0 0 55555555 00000000 00000000 00 1 0 0 0 0 0 00 00000000
0 1 2 3 00000040 00000000 00000000 00 0 0 0 0 0 0 00 00000000
0 1 2 0 00000040 000000a1 00000000 00 0 0 0 0 0 0 00 00000000
0 1 2 0 00000041 000000b2 00000000 00 0 0 0 0 0 0 00 00000000
0 1 2 0 00000042 000000c3 00000000 00 0 0 0 0 0 0 00 00000000
0 1 2 0 00000043 000000d4 00000000 00 0 0 0 0 0 0 00 00000000
0 1 1 0 00000040 00000000 00000000 05 1 1 3 0 0 1 05 d4c3b2a1
0 1 2 1 00000042 00009876 00000000 00 0 0 0 0 0 0 00 00000000
0 1 1 0 00000040 00000000 00000000 06 1 1 3 0 0 1 06 9876b2a1
0 1 2 1 00000040 00001234 00000000 00 0 0 0 0 0 0 00 00000000
0 1 1 0 00000040 00000000 00000000 07 1 1 3 0 0 1 07 98761234
0 1 2 3 00000044 12f07f81 00000000 00 0 0 0 0 0 0 00 00000000
0 1 1 0 00000044 00000000 00000000 08 1 1 0 0 0 1 08 ffffff81
0 1 1 0 00000044 00000000 00000000 09 1 1 0 1 0 1 09 00000081
0 1 1 0 00000045 00000000 00000000 0a 1 1 0 0 0 1 0a 0000007f
0 1 1 0 00000046 00000000 00000000 0b 1 1 0 0 0 1 0b fffffff0
0 1 1 0 00000047 00000000 00000000 0c 1 1 0 0 0 1 0c 00000012
0 1 2 3 00000050 9a70ee05 00000000 00 0 0 0 0 0 0 00 00000000
0 1 1 0 00000050 00000000 00000000 0d 1 1 0 0 0 1 0d 00000005
0 1 1 0 00000051 00000000 00000000 0e 1 1 0 0 0 1 0e ffffffee
0 1 1 0 00000052 00000000 00000000 0f 1 1 0 0 0 1 0f 00000070
0 1 1 0 00000053 00000000 00000000 10 1 1 0 1 0 1 10 0000009a
0 1 1 0 00000044 00000000 00000000 11 1 1 1 0 0 1 11 00007f81
0 1 1 0 00000046 00000000 00000000 12 1 1 1 0 0 1 12 000012f0
0 1 2 3 00000048 8000ffff 00000000 00 0 0 0 0 0 0 00 00000000
0 1 1 0 00000048 00000000 00000000 13 1 1 1 0 0 1 13 ffffffff
0 1 1 0 00000048 00000000 00000000 14 1 1 1 1 0 1 14 0000ffff
0 1 1 0 0000004a 00000000 00000000 15 1 1 1 0 0 1 15 ffff8000
0 1 1 0 00000048 00000000 00000000 16 1 1 3 1 0 1 16 8000ffff
0 1 0 0 00000000 00000000 0000abcd 17 1 0 0 0 1 1 17 abcd0000
0 1 1 0 00000040 00000000 ffff8765 18 1 0 3 0 1 1 18 87650000
0 1 2 3 0000004c 13572468 00000000 00 0 0 0 0 0 0 00 00000000
1 1 1 0 0000004c 00000000 00000000 19 1 1 3 0 0 1 19 13572468
1 1 0 0 00000001 00000000 00000000 1a 1 0 0 0 0 1 1a 00000001
1 1 0 0 00000002 00000000 00000000 1a 1 0 0 0 0 1 1a 00000002
1 1 0 0 00000003 00000000 00000000 1a 1 0 0 0 0 1 1a 00000003

//--- mips_mem_wb.f
verilog/mips_mem_wb_pkg.sv
verilog/mips_data_memory.sv
verilog/mips_mem_wb_reg.sv
verilog/mips_writeback.sv
verilog/mips_register_file.sv
verilog/mips_mem_wb_top.sv
bench/mips_mem_wb_checker.sv
bench/mips_mem_wb_tb.sv

//--- run_mips_mem_wb.sh
#!/usr/bin/env bash
# Builds the MEM/WB testbench with Verilator and runs it from the project root.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    -f mips_mem_wb.f \
    --top-module mips_mem_wb_tb \
    -Mdir obj_dir

./obj_dir/Vmips_mem_wb_tb | tee sim.log

if grep -qx "TEST PASSED" sim.log; then
    exit 0
else
    exit 1
fi

//--- verilog/mips_data_memory.sv
`timescale 1ns/1ps

module mips_data_memory
(
    input  logic                                i_clk,
    input  logic                                i_rst_n,
    input  mips_mem_wb_pkg::mem_stage_t         i_mem,
    output logic [mips_mem_wb_pkg::NBITS-1:0]   o_rdata
);

    logic [mips_mem_wb_pkg::DMEM_AWIDTH-1:0]    word_idx;
    logic [1:0]                                 byte_off;
    logic                                       store_en;
    logic [3:0]                                 lane_mask;
    logic [mips_mem_wb_pkg::NBITS-1:0]          lane_data;
    mips_mem_wb_pkg::access_size_e              access_size;

    // Four byte lanes per word.
    logic [3:0][7:0] mem_q [mips_mem_wb_pkg::DMEM_WORDS];

    assign word_idx = i_mem.alu_result[mips_mem_wb_pkg::DMEM_AWIDTH+1:2];
    assign byte_off = i_mem.alu_result[1:0];
    assign store_en = i_mem.valid && (i_mem.mem_op == mips_mem_wb_pkg::MEM_STORE);

    // Size of the current access, load or store.
    assign access_size = (i_mem.mem_op == mips_mem_wb_pkg::MEM_STORE) ?
                         i_mem.store_size : i_mem.wb.load_size;

    always_comb
    begin
        lane_mask = 4'b0000;
        lane_data = i_mem.store_data;
        case (i_mem.store_size)
            mips_mem_wb_pkg::SIZE_BYTE:
            begin
                lane_mask = 4'b0001 << byte_off;
                lane_data = {4{i_mem.store_data[7:0]}};     // Byte in every lane.
            end
            mips_mem_wb_pkg::SIZE_HALF:
            begin
                lane_mask = byte_off[1] ? 4'b1100 : 4'b0011;
                lane_data = {2{i_mem.store_data[15:0]}};
            end
            mips_mem_wb_pkg::SIZE_WORD:
            begin
                lane_mask = 4'b1111;
                lane_data = i_mem.store_data;
            end
            default:
            begin
                lane_mask = 4'b0000;
            end
        endcase
    end

    always_ff @(posedge i_clk)
    begin
        if (store_en)
        begin
            for (int lane = 0; lane < 4; lane++)
            begin
                if (lane_mask[lane])
                begin
                    mem_q[word_idx][lane] <= lane_data[lane*8 +: 8];
                end
            end
        end
    end

    // Old word is seen by a load in the storing cycle.
    assign o_rdata = mem_q[word_idx];

    a_half_aligned: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_mem.valid && (i_mem.mem_op != mips_mem_wb_pkg::MEM_NONE) &&
         (access_size == mips_mem_wb_pkg::SIZE_HALF)) |-> !byte_off[0])
        else $error("misaligned halfword access at %h", i_mem.alu_result);

    a_word_aligned: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_mem.valid && (i_mem.mem_op != mips_mem_wb_pkg::MEM_NONE) &&
         (access_size == mips_mem_wb_pkg::SIZE_WORD)) |-> (byte_off == 2'b00))
        else $error("misaligned word access at %h", i_mem.alu_result);

endmodule

//--- verilog/mips_mem_wb_pkg.sv
package mips_mem_wb_pkg;

    localparam int NBITS       = 32;    // Data and address width.
    localparam int RNBITS      = 5;     // Register index width.
    localparam int NREGS       = 32;
    localparam int DMEM_WORDS  = 256;
    localparam int DMEM_AWIDTH = 8;     // Word index, above the byte offset.

    typedef enum logic [1:0]
    {
        MEM_NONE  = 2'b00,
        MEM_LOAD  = 2'b01,
        MEM_STORE = 2'b10
    } mem_op_e;

    // Same encoding for load filter and store size.
    typedef enum logic [1:0]
    {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b11
    } access_size_e;

    typedef struct packed
    {
        logic                   reg_write;
        logic                   mem_to_reg;
        access_size_e           load_size;
        logic                   zero_extend;
        logic                   lui;
    } wb_ctrl_t;

    typedef struct packed
    {
        logic                   valid;
        mem_op_e                mem_op;
        access_size_e           store_size;
        logic [NBITS-1:0]       alu_result;
        logic [NBITS-1:0]       store_data;
        logic [NBITS-1:0]       extension;
        logic [RNBITS-1:0]      rd;
        wb_ctrl_t               wb;
    } mem_stage_t;

    typedef struct packed
    {
        logic                   valid;
        logic [NBITS-1:0]       alu_result;
        logic [NBITS-1:0]       mem_word;       // Raw word, filtered in WB.
        logic [1:0]             byte_offset;
        logic [NBITS-1:0]       extension;
        logic [RNBITS-1:0]      rd;
        wb_ctrl_t               wb;
    } mem_wb_t;

    typedef struct packed
    {
        logic                   en;
        logic [RNBITS-1:0]      rd;
        logic [NBITS-1:0]       data;
    } wb_write_t;

endpackage

//--- verilog/mips_mem_wb_reg.sv
`timescale 1ns/1ps

module mips_mem_wb_reg
(
    input  logic                                i_clk,
    input  logic                                i_rst_n,
    input  mips_mem_wb_pkg::mem_stage_t         i_mem,
    input  logic [mips_mem_wb_pkg::NBITS-1:0]   i_mem_word,
    output mips_mem_wb_pkg::mem_wb_t            o_mem_wb
);

    logic                                       valid_q;
    mips_mem_wb_pkg::wb_ctrl_t                  wb_q;
    logic [mips_mem_wb_pkg::NBITS-1:0]          alu_result_q;
    logic [mips_mem_wb_pkg::NBITS-1:0]          mem_word_q;
    logic [1:0]                                 byte_offset_q;
    logic [mips_mem_wb_pkg::NBITS-1:0]          extension_q;
    logic [mips_mem_wb_pkg::RNBITS-1:0]         rd_q;

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            valid_q <= 1'b0;
            wb_q    <= '0;      // No register write after reset.
        end
        else
        begin
            valid_q <= i_mem.valid;
            wb_q    <= i_mem.wb;
        end
    end

    always_ff @(posedge i_clk)
    begin
        alu_result_q  <= i_mem.alu_result;
        mem_word_q    <= i_mem_word;
        byte_offset_q <= i_mem.alu_result[1:0];     // Lane for the load filter.
        extension_q   <= i_mem.extension;
        rd_q          <= i_mem.rd;
    end

    always_comb
    begin
        o_mem_wb.valid       = valid_q;
        o_mem_wb.alu_result  = alu_result_q;
        o_mem_wb.mem_word    = mem_word_q;
        o_mem_wb.byte_offset = byte_offset_q;
        o_mem_wb.extension   = extension_q;
        o_mem_wb.rd          = rd_q;
        o_mem_wb.wb          = wb_q;
    end

    a_ctrl_known: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        valid_q |-> !$isunknown(wb_q))
        else $error("unknown writeback control on a valid entry");

endmodule

//--- verilog/mips_mem_wb_top.sv
`timescale 1ns/1ps

module mips_mem_wb_top
(
    input  logic                                i_clk,
    input  logic                                i_rst_n,
    input  mips_mem_wb_pkg::mem_stage_t         i_mem,
    input  logic [mips_mem_wb_pkg::RNBITS-1:0]  i_raddr_a,
    input  logic [mips_mem_wb_pkg::RNBITS-1:0]  i_raddr_b,
    output mips_mem_wb_pkg::wb_write_t          o_wb,
    output logic [mips_mem_wb_pkg::NBITS-1:0]   o_rdata_a,
    output logic [mips_mem_wb_pkg::NBITS-1:0]   o_rdata_b
);

    logic [mips_mem_wb_pkg::NBITS-1:0]  mem_word;
    mips_mem_wb_pkg::mem_wb_t           mem_wb;

    // Addressed word, combinational.
    mips_data_memory u_dmem
    (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_mem      (i_mem),
        .o_rdata    (mem_word)
    );

    mips_mem_wb_reg u_mem_wb_reg
    (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_mem      (i_mem),
        .i_mem_word (mem_word),
        .o_mem_wb   (mem_wb)
    );

    mips_writeback u_writeback
    (
        .i_mem_wb   (mem_wb),
        .o_wb       (o_wb)
    );

    // Writeback result also feeds the write port.
    mips_register_file u_regfile
    (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_wb       (o_wb),
        .i_raddr_a  (i_raddr_a),
        .i_raddr_b  (i_raddr_b),
        .o_rdata_a  (o_rdata_a),
        .o_rdata_b  (o_rdata_b)
    );

endmodule

//--- verilog/mips_register_file.sv
`timescale 1ns/1ps

module mips_register_file
(
    input  logic                                i_clk,
    input  logic                                i_rst_n,
    input  mips_mem_wb_pkg::wb_write_t          i_wb,
    input  logic [mips_mem_wb_pkg::RNBITS-1:0]  i_raddr_a,
    input  logic [mips_mem_wb_pkg::RNBITS-1:0]  i_raddr_b,
    output logic [mips_mem_wb_pkg::NBITS-1:0]   o_rdata_a,
    output logic [mips_mem_wb_pkg::NBITS-1:0]   o_rdata_b
);

    localparam int NBITS  = mips_mem_wb_pkg::NBITS;
    localparam int RNBITS = mips_mem_wb_pkg::RNBITS;

    logic [NBITS-1:0] regs_q [mips_mem_wb_pkg::NREGS];

    // Register zero reads zero and a write in flight is passed through.
    function automatic logic [NBITS-1:0] read_port(input logic [RNBITS-1:0] addr);
        logic [NBITS-1:0] value;
        if (addr == '0)
            value = '0;
        else if (i_wb.en && (i_wb.rd == addr))
            value = i_wb.data;
        else
            value = regs_q[addr];
        return value;
    endfunction

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            for (int r = 0; r < mips_mem_wb_pkg::NREGS; r++)
            begin
                regs_q[r] <= '0;
            end
        end
        else if (i_wb.en && (i_wb.rd != '0))
        begin
            regs_q[i_wb.rd] <= i_wb.data;
        end
    end

    always_comb
    begin
        o_rdata_a = read_port(i_raddr_a);
        o_rdata_b = read_port(i_raddr_b);
    end

    // An enabled write carries a known index and value.
    a_write_known: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_wb.en |-> !$isunknown({i_wb.rd, i_wb.data}))
        else $error("register write with unknown index or data");

endmodule

//--- verilog/mips_writeback.sv
`timescale 1ns/1ps

module mips_writeback
(
    input  mips_mem_wb_pkg::mem_wb_t            i_mem_wb,
    output mips_mem_wb_pkg::wb_write_t          o_wb
);

    localparam int NBITS = mips_mem_wb_pkg::NBITS;

    logic [7:0]         load_byte;
    logic [15:0]        load_half;
    logic [NBITS-1:0]   load_value;
    logic [NBITS-1:0]   lui_value;
    logic [NBITS-1:0]   result;

    always_comb
    begin
        case (i_mem_wb.byte_offset)
            2'd0:    load_byte = i_mem_wb.mem_word[7:0];
            2'd1:    load_byte = i_mem_wb.mem_word[15:8];
            2'd2:    load_byte = i_mem_wb.mem_word[23:16];
            default: load_byte = i_mem_wb.mem_word[31:24];
        endcase
        load_half = i_mem_wb.byte_offset[1] ? i_mem_wb.mem_word[31:16] :
                                              i_mem_wb.mem_word[15:0];
    end

    always_comb
    begin
        case (i_mem_wb.wb.load_size)
            mips_mem_wb_pkg::SIZE_BYTE:
            begin
                if (i_mem_wb.wb.zero_extend)
                    load_value = {{(NBITS-8){1'b0}}, load_byte};
                else
                    load_value = {{(NBITS-8){load_byte[7]}}, load_byte};
            end
            mips_mem_wb_pkg::SIZE_HALF:
            begin
                if (i_mem_wb.wb.zero_extend)
                    load_value = {{(NBITS-16){1'b0}}, load_half};
                else
                    load_value = {{(NBITS-16){load_half[15]}}, load_half};
            end
            default:
            begin
                load_value = i_mem_wb.mem_word;     // Word ignores zero_extend.
            end
        endcase
    end

    assign lui_value = {i_mem_wb.extension[15:0], 16'h0000};

    // lui wins over mem_to_reg.
    always_comb
    begin
        if (i_mem_wb.wb.lui)
            result = lui_value;
        else if (i_mem_wb.wb.mem_to_reg)
            result = load_value;
        else
            result = i_mem_wb.alu_result;
    end

    assign o_wb.en   = i_mem_wb.valid && i_mem_wb.wb.reg_write && (i_mem_wb.rd != '0);
    assign o_wb.rd   = i_mem_wb.rd;
    assign o_wb.data = result;

    always_comb
    begin
        if (i_mem_wb.valid)
        begin
            a_lui_xor_load: assert (!(i_mem_wb.wb.lui && i_mem_wb.wb.mem_to_reg))
                else $error("lui and mem_to_reg both set on a valid entry");
        end
    end

endmodule
